//--- run_sim.sh
#!/bin/sh
# build the Magma testbench with Verilator, run it and scan the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module magma_tb -o magma_sim \
  && ./obj_dir/magma_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- source/magma_consts.svh
`ifndef MAGMA_CONSTS_SVH
`define MAGMA_CONSTS_SVH

// rounds per 64-bit block
`define MAGMA_ROUNDS 32

// 32-bit words in the 256-bit key
`define MAGMA_KEY_WORDS 8

// engines sharing the key read port
`define MAGMA_ENGINES 2

`endif

//--- source/magma_engine.sv
`default_nettype none

`include "magma_consts.svh"

module magma_engine #(
  parameter bit DECRYPT = 1'b0
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       start,
  input  wire  magma_pkg::block_t   block,
  output logic                      key_req,
  output magma_pkg::key_idx_t       key_idx,
  input  wire                       key_gnt,
  input  wire  magma_pkg::half_t    key_data,
  output logic                      busy,
  output logic                      done,
  output magma_pkg::block_t         result
);

  localparam int LAST = `MAGMA_ROUNDS - 1;

  // first round that walks the key words backwards
  localparam int SWITCH = DECRYPT ? `MAGMA_KEY_WORDS : `MAGMA_ROUNDS - `MAGMA_KEY_WORDS;

  logic                busy_q;
  logic                done_q;
  // key word for round_q is on key_data this cycle
  logic                pend_q;
  magma_pkg::round_t   round_q;
  magma_pkg::round_t   req_round;
  logic                last_round;

  magma_pkg::half_t    left_q;
  magma_pkg::half_t    right_q;
  magma_pkg::half_t    left_nxt;
  magma_pkg::half_t    right_nxt;

  assign last_round = pend_q && (round_q == magma_pkg::round_t'(LAST));

  // while a word returns, the next round is already requested
  assign req_round = pend_q ? magma_pkg::round_t'(round_q + 1'b1) : round_q;

  assign key_req = busy_q && !last_round;

  always_comb begin
    if (req_round < SWITCH) begin
      key_idx = magma_pkg::key_idx_t'(req_round);
    end else begin
      key_idx = ~magma_pkg::key_idx_t'(req_round);
    end
  end

  magma_round u_round (
    .left     (left_q),
    .right    (right_q),
    .round_key(key_data),
    .left_out (left_nxt),
    .right_out(right_nxt)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      pend_q  <= 1'b0;
      round_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (!busy_q) begin
        pend_q <= 1'b0;
        if (start) begin
          busy_q  <= 1'b1;
          round_q <= '0;
        end
      end else begin
        pend_q <= key_gnt;
        if (pend_q) begin
          round_q <= round_q + 1'b1;
          if (last_round) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end
    end
  end

  // block halves, loaded on start and updated once per returned word
  always_ff @(posedge clk) begin
    if (!busy_q && start) begin
      left_q  <= block[63:32];
      right_q <= block[31:0];
    end else if (busy_q && pend_q) begin
      left_q  <= left_nxt;
      right_q <= right_nxt;
    end
  end

  assign busy = busy_q;
  assign done = done_q;

  // the last swap is undone on output
  assign result = {right_q, left_q};

endmodule

`default_nettype wire

//--- source/magma_key_arbiter.sv
`default_nettype none

`include "magma_consts.svh"

module magma_key_arbiter (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       enc_req,
  input  wire  magma_pkg::key_idx_t enc_idx,
  input  wire                       dec_req,
  input  wire  magma_pkg::key_idx_t dec_idx,
  output logic                      enc_gnt,
  output logic                      dec_gnt,
  output logic                      rd_en,
  output magma_pkg::key_idx_t       rd_addr
);

  // bit 0 is the encrypt engine, bit 1 the decrypt engine
  logic [`MAGMA_ENGINES-1:0] req;
  logic [`MAGMA_ENGINES-1:0] gnt;

  // engine granted most recently, 1 for decrypt
  logic last_q;

  assign req = {dec_req, enc_req};

  always_comb begin
    gnt = '0;
    if (&req) begin
      // contested, the engine that waited wins
      gnt[!last_q] = 1'b1;
    end else begin
      gnt = req;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_q <= 1'b1;
    end else if (|gnt) begin
      last_q <= gnt[1];
    end
  end

  assign enc_gnt = gnt[0];
  assign dec_gnt = gnt[1];

  assign rd_en   = |gnt;
  assign rd_addr = gnt[1] ? dec_idx : enc_idx;

endmodule

`default_nettype wire

//--- source/magma_key_store.sv
`default_nettype none

`include "magma_consts.svh"

module magma_key_store (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       key_we,
  input  wire  magma_pkg::key_idx_t key_addr,
  input  wire  magma_pkg::half_t    key_wdata,
  input  wire                       rd_en,
  input  wire  magma_pkg::key_idx_t rd_addr,
  output magma_pkg::half_t          rd_data
);

  magma_pkg::half_t mem [`MAGMA_KEY_WORDS];

  always_ff @(posedge clk) begin
    if (key_we) begin
      mem[key_addr] <= key_wdata;
    end
  end

  // same-word read during a write sees the old word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- source/magma_pkg.sv
`default_nettype none

`include "magma_consts.svh"

package magma_pkg;

  // one half of a block, also one round key word
  typedef logic [31:0] half_t;

  // left half in the upper 32 bits
  typedef logic [63:0] block_t;

  // word 0 holds key bits 255..224
  typedef logic [$clog2(`MAGMA_KEY_WORDS)-1:0] key_idx_t;

  typedef logic [$clog2(`MAGMA_ROUNDS)-1:0] round_t;

endpackage

`default_nettype wire

//--- source/magma_round.sv
`default_nettype none

module magma_round (
  input  wire  magma_pkg::half_t left,
  input  wire  magma_pkg::half_t right,
  input  wire  magma_pkg::half_t round_key,
  output magma_pkg::half_t       left_out,
  output magma_pkg::half_t       right_out
);

  magma_pkg::half_t sum;
  magma_pkg::half_t subst;
  magma_pkg::half_t rotated;

  // modulo 2^32 key addition
  assign sum = right + round_key;

  for (genvar i = 0; i < 8; i++) begin : g_box
    magma_sbox u_sbox (
      .box_sel   (3'(i)),
      .nibble_in (sum[i*4 +: 4]),
      .nibble_out(subst[i*4 +: 4])
    );
  end

  // rotate left by 11
  assign rotated = {subst[20:0], subst[31:21]};

  // halves swap after mixing
  assign left_out  = right;
  assign right_out = left ^ rotated;

endmodule

`default_nettype wire

//--- source/magma_sbox.sv
`default_nettype none

module magma_sbox (
  input  wire  [2:0] box_sel,
  input  wire  [3:0] nibble_in,
  output logic [3:0] nibble_out
);

  // eight boxes of sixteen entries, box n at entries 16n..16n+15
  localparam logic [3:0] SBOX [128] = '{
    // box 0 serves the lowest nibble
    4'd12, 4'd4,  4'd6,  4'd2,  4'd10, 4'd5,  4'd11, 4'd9,
    4'd14, 4'd8,  4'd13, 4'd7,  4'd0,  4'd3,  4'd15, 4'd1,
    // box 1
    4'd6,  4'd8,  4'd2,  4'd3,  4'd9,  4'd10, 4'd5,  4'd12,
    4'd1,  4'd14, 4'd4,  4'd7,  4'd11, 4'd13, 4'd0,  4'd15,
    // box 2
    4'd11, 4'd3,  4'd5,  4'd8,  4'd2,  4'd15, 4'd10, 4'd13,
    4'd14, 4'd1,  4'd7,  4'd4,  4'd12, 4'd9,  4'd6,  4'd0,
    // box 3
    4'd12, 4'd8,  4'd2,  4'd1,  4'd13, 4'd4,  4'd15, 4'd6,
    4'd7,  4'd0,  4'd10, 4'd5,  4'd3,  4'd14, 4'd9,  4'd11,
    // box 4
    4'd7,  4'd15, 4'd5,  4'd10, 4'd8,  4'd1,  4'd6,  4'd13,
    4'd0,  4'd9,  4'd3,  4'd14, 4'd11, 4'd4,  4'd2,  4'd12,
    // box 5
    4'd5,  4'd13, 4'd15, 4'd6,  4'd9,  4'd2,  4'd12, 4'd10,
    4'd11, 4'd7,  4'd8,  4'd1,  4'd4,  4'd3,  4'd14, 4'd0,
    // box 6
    4'd8,  4'd14, 4'd2,  4'd5,  4'd6,  4'd9,  4'd1,  4'd12,
    4'd15, 4'd4,  4'd11, 4'd0,  4'd13, 4'd10, 4'd3,  4'd7,
    // box 7 serves the top nibble
    4'd1,  4'd7,  4'd14, 4'd13, 4'd0,  4'd5,  4'd8,  4'd3,
    4'd4,  4'd15, 4'd10, 4'd6,  4'd9,  4'd12, 4'd11, 4'd2
  };

  assign nibble_out = SBOX[{box_sel, nibble_in}];

endmodule

`default_nettype wire

//--- source/magma_top.sv
`default_nettype none

module magma_top (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       key_we,
  input  wire  magma_pkg::key_idx_t key_addr,
  input  wire  magma_pkg::half_t    key_wdata,
  input  wire                       enc_start,
  input  wire  magma_pkg::block_t   enc_block,
  output magma_pkg::block_t         enc_result,
  output logic                      enc_busy,
  output logic                      enc_done,
  input  wire                       dec_start,
  input  wire  magma_pkg::block_t   dec_block,
  output magma_pkg::block_t         dec_result,
  output logic                      dec_busy,
  output logic                      dec_done
);

  logic                enc_req;
  logic                dec_req;
  logic                enc_gnt;
  logic                dec_gnt;
  magma_pkg::key_idx_t enc_idx;
  magma_pkg::key_idx_t dec_idx;
  logic                rd_en;
  magma_pkg::key_idx_t rd_addr;
  magma_pkg::half_t    rd_data;

  magma_key_store u_key_store (
    .clk      (clk),
    .rst_n    (rst_n),
    .key_we   (key_we),
    .key_addr (key_addr),
    .key_wdata(key_wdata),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  magma_key_arbiter u_key_arbiter (
    .clk    (clk),
    .rst_n  (rst_n),
    .enc_req(enc_req),
    .enc_idx(enc_idx),
    .dec_req(dec_req),
    .dec_idx(dec_idx),
    .enc_gnt(enc_gnt),
    .dec_gnt(dec_gnt),
    .rd_en  (rd_en),
    .rd_addr(rd_addr)
  );

  // both engines see the same read data
  magma_engine #(.DECRYPT(1'b0)) u_enc_engine (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (enc_start),
    .block   (enc_block),
    .key_req (enc_req),
    .key_idx (enc_idx),
    .key_gnt (enc_gnt),
    .key_data(rd_data),
    .busy    (enc_busy),
    .done    (enc_done),
    .result  (enc_result)
  );

  magma_engine #(.DECRYPT(1'b1)) u_dec_engine (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (dec_start),
    .block   (dec_block),
    .key_req (dec_req),
    .key_idx (dec_idx),
    .key_gnt (dec_gnt),
    .key_data(rd_data),
    .busy    (dec_busy),
    .done    (dec_done),
    .result  (dec_result)
  );

endmodule

`default_nettype wire

//--- tests/magma_ref_model.svh
`ifndef MAGMA_REF_MODEL_SVH
`define MAGMA_REF_MODEL_SVH

// substitution box n, entry 0 in the top nibble, box 0 for the lowest input nibble
localparam logic [63:0] PI_TABLE [8] = '{
  64'hc462a5b9e8d703f1,
  64'h68239a5c1e47bd0f,
  64'hb3582fade174c960,
  64'hc821d4f670a53e9b,
  64'h7f5a816d093eb42c,
  64'h5df692cab78143e0,
  64'h8e25691cf4b0da37,
  64'h17ed05834fa69cb2
};

// g function: add key, substitute nibbles, rotate left by 11
function automatic magma_pkg::half_t mix_half(input magma_pkg::half_t a,
                                              input magma_pkg::half_t k);
  magma_pkg::half_t s;
  magma_pkg::half_t t;
  int n;
  s = a + k;
  for (int i = 0; i < 8; i++) begin
    n = int'(s[4*i +: 4]);
    t[4*i +: 4] = PI_TABLE[i][63 - 4*n -: 4];
  end
  return (t << 11) | (t >> 21);
endfunction

// K1..K8 three times, then K8..K1; decryption walks that list backwards
function automatic magma_pkg::half_t schedule_word(input logic [255:0] key, input int r,
                                                   input bit decrypt);
  int er;
  int w;
  er = decrypt ? `MAGMA_ROUNDS - 1 - r : r;
  w  = (er < `MAGMA_ROUNDS - `MAGMA_KEY_WORDS) ? er % `MAGMA_KEY_WORDS : `MAGMA_ROUNDS - 1 - er;
  return key[255 - 32*w -: 32];
endfunction

function automatic magma_pkg::block_t cipher_block(input logic [255:0] key,
                                                   input magma_pkg::block_t blk,
                                                   input bit decrypt);
  magma_pkg::half_t a1;
  magma_pkg::half_t a0;
  magma_pkg::half_t t;
  a1 = blk[63:32];
  a0 = blk[31:0];
  for (int r = 0; r < `MAGMA_ROUNDS; r++) begin
    t  = a1 ^ mix_half(a0, schedule_word(key, r, decrypt));
    a1 = a0;
    a0 = t;
  end
  // the last round does not swap
  return {a0, a1};
endfunction

`endif

//--- tests/magma_tb.sv
`default_nettype none

`include "magma_consts.svh"

module magma_tb;

  timeunit 1ns;
  timeprecision 1ps;

  `include "magma_ref_model.svh"

  localparam int CLK_PERIOD   = 10;
  localparam int NUM_RANDOM   = 20;
  localparam int NUM_TXN      = 2 + 2 + 2 * NUM_RANDOM + 1;
  localparam int SOLO_LATENCY = `MAGMA_ROUNDS + 1;
  // every round can lose one cycle to the other engine
  localparam int MAX_LATENCY  = 2 * `MAGMA_ROUNDS + 1;

  localparam logic [255:0] STD_KEY =
    256'hffeeddccbbaa99887766554433221100f0f1f2f3f4f5f6f7f8f9fafbfcfdfeff;
  localparam magma_pkg::block_t STD_PT = 64'hfedcba9876543210;
  localparam magma_pkg::block_t STD_CT = 64'h4ee901e5c2d8ca3d;

  logic                clk;
  logic                rst_n;
  logic                key_we;
  magma_pkg::key_idx_t key_addr;
  magma_pkg::half_t    key_wdata;
  logic                enc_start;
  magma_pkg::block_t   enc_block;
  magma_pkg::block_t   enc_result;
  logic                enc_busy;
  logic                enc_done;
  logic                dec_start;
  magma_pkg::block_t   dec_block;
  magma_pkg::block_t   dec_result;
  logic                dec_busy;
  logic                dec_done;

  int                  seed;
  logic                solo_run;
  logic [255:0]        cur_key;
  logic [255:0]        key_val;
  magma_pkg::block_t   exp_enc;
  magma_pkg::block_t   exp_dec;
  magma_pkg::block_t   blk_a;
  magma_pkg::block_t   blk_b;
  magma_pkg::block_t   ct;

  // in-flight flag, cycles since the start edge and held-result flag of each engine
  logic                enc_active;
  int                  enc_cycles;
  logic                enc_has_result;
  logic                dec_active;
  int                  dec_cycles;
  logic                dec_has_result;

  magma_top u_magma_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .key_we    (key_we),
    .key_addr  (key_addr),
    .key_wdata (key_wdata),
    .enc_start (enc_start),
    .enc_block (enc_block),
    .enc_result(enc_result),
    .enc_busy  (enc_busy),
    .enc_done  (enc_done),
    .dec_start (dec_start),
    .dec_block (dec_block),
    .dec_result(dec_result),
    .dec_busy  (dec_busy),
    .dec_done  (dec_done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      enc_active     <= 1'b0;
      enc_cycles     <= 0;
      enc_has_result <= 1'b0;
    end else if (!enc_active) begin
      if (enc_start) begin
        enc_active     <= 1'b1;
        enc_cycles     <= 0;
        enc_has_result <= 1'b0;
      end
    end else if (enc_done) begin
      enc_active     <= 1'b0;
      enc_has_result <= 1'b1;
    end else begin
      enc_cycles <= enc_cycles + 1;
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      dec_active     <= 1'b0;
      dec_cycles     <= 0;
      dec_has_result <= 1'b0;
    end else if (!dec_active) begin
      if (dec_start) begin
        dec_active     <= 1'b1;
        dec_cycles     <= 0;
        dec_has_result <= 1'b0;
      end
    end else if (dec_done) begin
      dec_active     <= 1'b0;
      dec_has_result <= 1'b1;
    end else begin
      dec_cycles <= dec_cycles + 1;
    end
  end

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  enc_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
    !enc_active |-> (!enc_busy && !enc_done))
    else report_failure($sformatf("[FAIL] %0t: encrypt busy or done while idle", $time));
  enc_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
    (enc_active && !enc_done) |-> (enc_busy && enc_cycles < MAX_LATENCY))
    else report_failure($sformatf("[FAIL] %0t: encrypt busy low or done late", $time));
  enc_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
    enc_done |-> (enc_active && enc_cycles >= SOLO_LATENCY &&
                  (!solo_run || enc_cycles == SOLO_LATENCY)))
    else report_failure($sformatf("[FAIL] %0t: encrypt done after %0d cycles", $time,
                                  enc_cycles));
  enc_result_a: assert property (@(posedge clk) disable iff (!rst_n)
    (enc_done || (!enc_active && enc_has_result && !enc_start)) |-> enc_result == exp_enc)
    else report_failure($sformatf("[FAIL] %0t: encrypt result %h, expected %h", $time,
                                  enc_result, exp_enc));

  dec_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
    !dec_active |-> (!dec_busy && !dec_done))
    else report_failure($sformatf("[FAIL] %0t: decrypt busy or done while idle", $time));
  dec_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
    (dec_active && !dec_done) |-> (dec_busy && dec_cycles < MAX_LATENCY))
    else report_failure($sformatf("[FAIL] %0t: decrypt busy low or done late", $time));
  dec_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
    dec_done |-> (dec_active && dec_cycles >= SOLO_LATENCY &&
                  (!solo_run || dec_cycles == SOLO_LATENCY)))
    else report_failure($sformatf("[FAIL] %0t: decrypt done after %0d cycles", $time,
                                  dec_cycles));
  dec_result_a: assert property (@(posedge clk) disable iff (!rst_n)
    (dec_done || (!dec_active && dec_has_result && !dec_start)) |-> dec_result == exp_dec)
    else report_failure($sformatf("[FAIL] %0t: decrypt result %h, expected %h", $time,
                                  dec_result, exp_dec));

  // word 0 takes key bits 255..224
  task automatic load_key(input logic [255:0] key);
    for (int w = 0; w < `MAGMA_KEY_WORDS; w++) begin
      @(negedge clk);
      key_we    = 1'b1;
      key_addr  = magma_pkg::key_idx_t'(w);
      key_wdata = key[255 - 32*w -: 32];
    end
    @(negedge clk);
    key_we  = 1'b0;
    cur_key = key;
  endtask

  task automatic launch_enc(input magma_pkg::block_t blk, input magma_pkg::block_t expected);
    @(negedge clk);
    enc_start = 1'b1;
    enc_block = blk;
    exp_enc   = expected;
    @(negedge clk);
    enc_start = 1'b0;
  endtask

  task automatic launch_dec(input magma_pkg::block_t blk, input magma_pkg::block_t expected);
    @(negedge clk);
    dec_start = 1'b1;
    dec_block = blk;
    exp_dec   = expected;
    @(negedge clk);
    dec_start = 1'b0;
  endtask

  task automatic await_enc_done();
    do @(negedge clk); while (!enc_done);
  endtask

  task automatic await_dec_done();
    do @(negedge clk); while (!dec_done);
  endtask

  initial begin
    #(NUM_TXN * 100 * CLK_PERIOD);
    report_failure("timeout: the tests did not finish within the watchdog limit");
  end

  initial begin
    seed      = 32'haaa3;
    rst_n     = 1'b0;
    key_we    = 1'b0;
    key_addr  = '0;
    key_wdata = '0;
    enc_start = 1'b0;
    enc_block = '0;
    dec_start = 1'b0;
    dec_block = '0;
    solo_run  = 1'b1;
    cur_key   = '0;
    exp_enc   = '0;
    exp_dec   = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (5) @(negedge clk);

    load_key(STD_KEY);
    launch_enc(STD_PT, STD_CT);
    await_enc_done();
    launch_dec(STD_CT, STD_PT);
    await_dec_done();

    // both engines start in the same cycle and share the key port
    solo_run = 1'b0;
    blk_a = {$random(seed), $random(seed)};
    blk_b = {$random(seed), $random(seed)};
    @(negedge clk);
    enc_start = 1'b1;
    enc_block = blk_a;
    exp_enc   = cipher_block(cur_key, blk_a, 1'b0);
    dec_start = 1'b1;
    dec_block = blk_b;
    exp_dec   = cipher_block(cur_key, blk_b, 1'b1);
    @(negedge clk);
    enc_start = 1'b0;
    dec_start = 1'b0;
    fork
      await_enc_done();
      await_dec_done();
    join
    @(negedge clk);
    solo_run = 1'b1;

    for (int n = 0; n < NUM_RANDOM; n++) begin
      for (int w = 0; w < `MAGMA_KEY_WORDS; w++) begin
        key_val[255 - 32*w -: 32] = $random(seed);
      end
      load_key(key_val);
      blk_a = {$random(seed), $random(seed)};
      ct    = cipher_block(cur_key, blk_a, 1'b0);
      launch_enc(blk_a, ct);
      await_enc_done();
      launch_dec(ct, blk_a);
      await_dec_done();
    end

    // a second start during busy must not disturb the first block
    blk_a = {$random(seed), $random(seed)};
    blk_b = ~blk_a;
    launch_enc(blk_a, cipher_block(cur_key, blk_a, 1'b0));
    repeat (5) @(negedge clk);
    enc_start = 1'b1;
    enc_block = blk_b;
    @(negedge clk);
    enc_start = 1'b0;
    await_enc_done();

    repeat (3) @(negedge clk);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
+incdir+tests
source/magma_pkg.sv
source/magma_sbox.sv
source/magma_round.sv
source/magma_key_store.sv
source/magma_key_arbiter.sv
source/magma_engine.sv
source/magma_top.sv
tests/magma_tb.sv
